// ==== pw_pkg.sv ====
package pw_pkg;

   ////////////////////////////////////////
   // sizes
   ////////////////////////////////////////
   localparam int PATTERN_BYTES     = 4;
   localparam int PATTERN_CNT_WIDTH = $clog2(PATTERN_BYTES + 1);
   localparam int TS_FULL_WIDTH     = 12;
   localparam int TS_SHORT_WIDTH    = 8;
   localparam int TRIG_CNT_WIDTH    = 8;
   localparam int CAPTURE_LEN_WIDTH = 8;
   localparam int FIFO_DEPTH        = 16;
   localparam int FIFO_ADDR_WIDTH   = $clog2(FIFO_DEPTH);
   localparam int FIFO_WORD_WIDTH   = 18;

   ////////////////////////////////////////
   // register map
   ////////////////////////////////////////
   localparam logic [7:0] REG_CTRL        = 8'h00; // [0] arm, [1] trigger enable
   localparam logic [7:0] REG_STATUS      = 8'h01;
   localparam logic [7:0] REG_PATTERN0    = 8'h04; // first packet byte at base
   localparam logic [7:0] REG_MASK0       = 8'h08;
   localparam logic [7:0] REG_TRIG_DELAY  = 8'h0c;
   localparam logic [7:0] REG_TRIG_WIDTH  = 8'h0d;
   localparam logic [7:0] REG_CAPTURE_LEN = 8'h0e;
   localparam logic [7:0] REG_FIFO_POP    = 8'h10;
   localparam logic [7:0] REG_FIFO_DATA0  = 8'h11; // low byte first

   // fifo word commands
   localparam logic [1:0] CMD_DATA = 2'b00;
   localparam logic [1:0] CMD_STAT = 2'b01;

   // trigger fsm states
   localparam logic [1:0] TRIG_IDLE  = 2'd0;
   localparam logic [1:0] TRIG_DELAY = 2'd1;
   localparam logic [1:0] TRIG_PULSE = 2'd2;

   // cmd sits in the top two bits of both views
   typedef union packed {
      struct packed {
         logic [1:0]                cmd;
         logic [TS_SHORT_WIDTH-1:0] ts;
         logic [7:0]                data;
      } dat;
      struct packed {
         logic [1:0]               cmd;
         logic [3:0]               stat; // rxactive, rxerror, sessvld, vbusvld
         logic [TS_FULL_WIDTH-1:0] ts;
      } sts;
   } fifo_word_u;

endpackage

// ==== pw_reg_file.sv ====
module pw_reg_file (
   input  logic                                   fe_clk,
   input  logic                                   rst_n_i,
   input  logic [7:0]                             reg_addr_i,
   input  logic [7:0]                             reg_wdata_i,
   input  logic                                   reg_wr_i,
   input  logic                                   reg_rd_i,
   input  logic                                   capturing_i,
   input  logic                                   capture_done_i,
   input  logic                                   trig_done_i,
   input  logic                                   fifo_empty_i,
   input  logic                                   fifo_full_i,
   input  pw_pkg::fifo_word_u                     fifo_head_i,
   output logic [7:0]                             reg_rdata_o,
   output logic                                   arm_o,
   output logic                                   trig_enable_o,
   output logic [pw_pkg::PATTERN_BYTES*8-1:0]     pattern_o,
   output logic [pw_pkg::PATTERN_BYTES*8-1:0]     mask_o,
   output logic [pw_pkg::TRIG_CNT_WIDTH-1:0]      trig_delay_o,
   output logic [pw_pkg::TRIG_CNT_WIDTH-1:0]      trig_width_o,
   output logic [pw_pkg::CAPTURE_LEN_WIDTH-1:0]   capture_len_o,
   output logic                                   fifo_pop_o
);
   import pw_pkg::*;

   logic [FIFO_WORD_WIDTH-1:0] hold_q;  // last popped fifo word
   logic                       done_q;
   logic [7:0]                 rd_mux;

   assign fifo_pop_o = reg_wr_i && (reg_addr_i == REG_FIFO_POP);

   ////////////////////////////////////////
   // control
   ////////////////////////////////////////
   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         arm_o         <= 1'b0;
         trig_enable_o <= 1'b0;
         done_q        <= 1'b0;
      end else begin
         done_q <= capture_done_i;
         if (capture_done_i && !done_q)
            arm_o <= 1'b0;  // end of capture disarms
         if (reg_wr_i && (reg_addr_i == REG_CTRL)) begin
            arm_o         <= reg_wdata_i[0];
            trig_enable_o <= reg_wdata_i[1];
         end
      end
   end

   // configuration
   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pattern_o     <= '0;
         mask_o        <= '0;
         trig_delay_o  <= '0;
         trig_width_o  <= '0;
         capture_len_o <= '0;
      end else if (reg_wr_i) begin
         for (int i = 0; i < PATTERN_BYTES; i++) begin
            if (reg_addr_i == REG_PATTERN0 + i)
               pattern_o[i*8 +: 8] <= reg_wdata_i;
            if (reg_addr_i == REG_MASK0 + i)
               mask_o[i*8 +: 8] <= reg_wdata_i;
         end
         case (reg_addr_i)
            REG_TRIG_DELAY:  trig_delay_o  <= reg_wdata_i;
            REG_TRIG_WIDTH:  trig_width_o  <= reg_wdata_i;
            REG_CAPTURE_LEN: capture_len_o <= reg_wdata_i;
            default: ;
         endcase
      end
   end

   always_ff @(posedge fe_clk) begin
      if (fifo_pop_o) begin
         if (fifo_empty_i)
            hold_q <= '0;
         else
            hold_q <= fifo_head_i;
      end
   end

   ////////////////////////////////////////
   // read decode
   ////////////////////////////////////////
   always_comb begin
      rd_mux = 8'h00;
      case (reg_addr_i)
         REG_CTRL:              rd_mux = {6'b0, trig_enable_o, arm_o};
         REG_STATUS:            rd_mux = {4'b0, trig_done_i, fifo_full_i, fifo_empty_i, capturing_i};
         REG_TRIG_DELAY:        rd_mux = trig_delay_o;
         REG_TRIG_WIDTH:        rd_mux = trig_width_o;
         REG_CAPTURE_LEN:       rd_mux = capture_len_o;
         REG_FIFO_DATA0:        rd_mux = hold_q[7:0];
         REG_FIFO_DATA0 + 8'd1: rd_mux = hold_q[15:8];
         REG_FIFO_DATA0 + 8'd2: rd_mux = 8'(hold_q[FIFO_WORD_WIDTH-1:16]);
         default: ;
      endcase
      for (int i = 0; i < PATTERN_BYTES; i++) begin
         if (reg_addr_i == REG_PATTERN0 + i)
            rd_mux = pattern_o[i*8 +: 8];
         if (reg_addr_i == REG_MASK0 + i)
            rd_mux = mask_o[i*8 +: 8];
      end
   end

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i)
         reg_rdata_o <= 8'h00;
      else if (reg_rd_i)
         reg_rdata_o <= rd_mux;  // held until next read
   end

endmodule

// ==== pw_fe_rx.sv ====
module pw_fe_rx (
   input  logic                             fe_clk,
   input  logic                             rst_n_i,
   input  logic [7:0]                       fe_data_i,
   input  logic                             fe_rxvalid_i,
   input  logic                             fe_rxactive_i,
   input  logic                             fe_rxerror_i,
   input  logic                             fe_sessvld_i,
   input  logic                             fe_vbusvld_i,
   output logic                             evt_valid_o,
   output logic [1:0]                       evt_cmd_o,
   output logic [7:0]                       evt_data_o,
   output logic [3:0]                       evt_stat_o,
   output logic [pw_pkg::TS_FULL_WIDTH-1:0] evt_time_o,
   output logic                             pkt_start_o
);
   import pw_pkg::*;

   logic [7:0]               data_r;
   logic                     rxvalid_r;
   logic [3:0]               stat_r;     // rxactive in bit 3
   logic [3:0]               stat_d;
   logic                     stat_chg;
   logic [TS_FULL_WIDTH-1:0] ts_cnt;
   logic [7:0]               hold_data;
   logic                     hold_vld;

   assign stat_chg = (stat_r != stat_d);

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rxvalid_r <= 1'b0;
         stat_r    <= '0;
         stat_d    <= '0;
         ts_cnt    <= '0;
      end else begin
         rxvalid_r <= fe_rxvalid_i;
         stat_r    <= {fe_rxactive_i, fe_rxerror_i, fe_sessvld_i, fe_vbusvld_i};
         stat_d    <= stat_r;
         ts_cnt    <= ts_cnt + 1'b1;  // free running
      end
   end

   always_ff @(posedge fe_clk) begin
      data_r <= fe_data_i;
   end

   ////////////////////////////////////////
   // status events ahead of bytes
   ////////////////////////////////////////
   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         evt_valid_o <= 1'b0;
         pkt_start_o <= 1'b0;
         hold_vld    <= 1'b0;
      end else begin
         evt_valid_o <= stat_chg | hold_vld | rxvalid_r;
         pkt_start_o <= stat_r[3] & ~stat_d[3];
         if (stat_chg)
            hold_vld <= hold_vld | rxvalid_r;  // byte waits one cycle
         else
            hold_vld <= hold_vld & rxvalid_r;
      end
   end

   always_ff @(posedge fe_clk) begin
      evt_time_o <= ts_cnt;
      if (stat_chg) begin
         evt_cmd_o  <= CMD_STAT;
         evt_stat_o <= stat_r;
      end else begin
         evt_cmd_o  <= CMD_DATA;
         evt_data_o <= hold_vld ? hold_data : data_r;
      end
      if (rxvalid_r && (stat_chg || hold_vld))
         hold_data <= data_r;
   end

endmodule

// ==== pw_pattern_match.sv ====
module pw_pattern_match (
   input  logic                               fe_clk,
   input  logic                               rst_n_i,
   input  logic                               arm_i,
   input  logic                               pkt_start_i,
   input  logic                               evt_valid_i,
   input  logic [1:0]                         evt_cmd_i,
   input  logic [7:0]                         evt_data_i,
   input  logic [pw_pkg::PATTERN_BYTES*8-1:0] pattern_i,
   input  logic [pw_pkg::PATTERN_BYTES*8-1:0] mask_i,
   output logic                               match_o
);
   import pw_pkg::*;

   logic [PATTERN_CNT_WIDTH-1:0] byte_cnt;
   logic                         eq_q;      // every byte so far matched
   logic                         fired;     // one match per arm
   logic                         data_evt;
   logic                         byte_ok;

   assign data_evt = evt_valid_i && (evt_cmd_i == CMD_DATA) && (byte_cnt < PATTERN_BYTES);
   assign byte_ok  = ((evt_data_i ^ pattern_i[byte_cnt*8 +: 8]) & mask_i[byte_cnt*8 +: 8])
                     == 8'h00;

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         byte_cnt <= '0;
         eq_q     <= 1'b0;  // nothing matches before the first packet
         fired    <= 1'b0;
         match_o  <= 1'b0;
      end else begin
         match_o <= 1'b0;
         if (!arm_i)
            fired <= 1'b0;
         if (pkt_start_i) begin
            byte_cnt <= '0;
            eq_q     <= 1'b1;
         end else if (data_evt) begin
            byte_cnt <= byte_cnt + 1'b1;
            eq_q     <= eq_q & byte_ok;
            if ((byte_cnt == PATTERN_BYTES - 1) && eq_q && byte_ok && arm_i && !fired) begin
               match_o <= 1'b1;
               fired   <= 1'b1;
            end
         end
      end
   end

endmodule

// ==== pw_trigger.sv ====
module pw_trigger (
   input  logic                              fe_clk,
   input  logic                              rst_n_i,
   input  logic                              match_i,
   input  logic                              trig_enable_i,
   input  logic [pw_pkg::TRIG_CNT_WIDTH-1:0] trig_delay_i,
   input  logic [pw_pkg::TRIG_CNT_WIDTH-1:0] trig_width_i,
   output logic                              cw_trig_o,
   output logic                              trig_done_o
);
   import pw_pkg::*;

   logic [1:0]                state;
   logic [TRIG_CNT_WIDTH-1:0] cnt;
   logic                      trig_q;

   assign cw_trig_o = trig_q & trig_enable_i;  // disable cuts the pulse at once

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state       <= TRIG_IDLE;
         cnt         <= '0;
         trig_q      <= 1'b0;
         trig_done_o <= 1'b0;
      end else begin
         case (state)
            TRIG_IDLE: begin
               if (match_i) begin
                  trig_done_o <= 1'b0;
                  cnt         <= '0;
                  if (trig_enable_i)
                     state <= TRIG_DELAY;
               end
            end
            TRIG_DELAY: begin
               if (!trig_enable_i) begin
                  state <= TRIG_IDLE;
               end else if (cnt == trig_delay_i) begin
                  cnt <= TRIG_CNT_WIDTH'(1);  // first pulse cycle
                  if (trig_width_i == '0) begin
                     state       <= TRIG_IDLE;
                     trig_done_o <= 1'b1;
                  end else begin
                     state  <= TRIG_PULSE;
                     trig_q <= 1'b1;
                  end
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            TRIG_PULSE: begin
               if (!trig_enable_i || (cnt == trig_width_i)) begin
                  state       <= TRIG_IDLE;
                  trig_q      <= 1'b0;
                  trig_done_o <= 1'b1;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: state <= TRIG_IDLE;
         endcase
      end
   end

endmodule

// ==== pw_capture_fifo.sv ====
module pw_capture_fifo (
   input  logic                                 fe_clk,
   input  logic                                 rst_n_i,
   input  logic                                 evt_valid_i,
   input  logic [1:0]                           evt_cmd_i,
   input  logic [7:0]                           evt_data_i,
   input  logic [3:0]                           evt_stat_i,
   input  logic [pw_pkg::TS_FULL_WIDTH-1:0]     evt_time_i,
   input  logic                                 match_i,
   input  logic [pw_pkg::CAPTURE_LEN_WIDTH-1:0] capture_len_i,
   input  logic                                 fifo_pop_i,
   output logic                                 capturing_o,
   output logic                                 capture_done_o,
   output pw_pkg::fifo_word_u                   fifo_head_o,
   output logic                                 fifo_empty_o,
   output logic                                 fifo_full_o
);
   import pw_pkg::*;

   fifo_word_u                   mem [FIFO_DEPTH];
   fifo_word_u                   wr_word;
   logic [FIFO_ADDR_WIDTH:0]     wr_ptr;    // msb tells full from empty
   logic [FIFO_ADDR_WIDTH:0]     rd_ptr;
   logic [CAPTURE_LEN_WIDTH-1:0] wr_cnt;
   logic                         overflow;  // blocks writes until next match
   logic                         fifo_wr;

   assign fifo_empty_o = (wr_ptr == rd_ptr);
   assign fifo_full_o  = (wr_ptr[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
                         (wr_ptr[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);
   assign fifo_wr      = evt_valid_i && capturing_o && !fifo_full_o && !overflow;
   assign fifo_head_o  = mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];

   // pack by command
   always_comb begin
      wr_word = '0;
      if (evt_cmd_i == CMD_STAT) begin
         wr_word.sts.cmd  = CMD_STAT;
         wr_word.sts.stat = evt_stat_i;
         wr_word.sts.ts   = evt_time_i;
      end else begin
         wr_word.dat.cmd  = CMD_DATA;
         wr_word.dat.ts   = evt_time_i[TS_SHORT_WIDTH-1:0];
         wr_word.dat.data = evt_data_i;
      end
   end

   ////////////////////////////////////////
   // capture control
   ////////////////////////////////////////
   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         capturing_o    <= 1'b0;
         capture_done_o <= 1'b0;
         overflow       <= 1'b0;
         wr_cnt         <= '0;
      end else if (match_i) begin
         capturing_o    <= (capture_len_i != '0);
         capture_done_o <= (capture_len_i == '0);
         overflow       <= 1'b0;
         wr_cnt         <= '0;
      end else if (capturing_o && evt_valid_i) begin
         if (fifo_wr) begin
            wr_cnt <= wr_cnt + 1'b1;
            if (wr_cnt + 1'b1 == capture_len_i) begin
               capturing_o    <= 1'b0;
               capture_done_o <= 1'b1;
            end
         end else begin
            overflow <= 1'b1;  // event dropped on a full fifo
         end
      end
   end

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (fifo_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (fifo_pop_i && !fifo_empty_o)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge fe_clk) begin
      if (fifo_wr)
         mem[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= wr_word;
   end

endmodule

// ==== phywhisperer_top.sv ====
module phywhisperer_top (
   input  logic       fe_clk,
   input  logic       rst_n_i,
   input  logic [7:0] fe_data_i,
   input  logic       fe_rxvalid_i,
   input  logic       fe_rxactive_i,
   input  logic       fe_rxerror_i,
   input  logic       fe_sessvld_i,
   input  logic       fe_vbusvld_i,
   input  logic [7:0] reg_addr_i,
   input  logic [7:0] reg_wdata_i,
   input  logic       reg_wr_i,
   input  logic       reg_rd_i,
   output logic [7:0] reg_rdata_o,
   output logic       cw_trig_o
);
   import pw_pkg::*;

   // configuration
   logic                         arm;
   logic                         trig_enable;
   logic [PATTERN_BYTES*8-1:0]   pattern;
   logic [PATTERN_BYTES*8-1:0]   mask;
   logic [TRIG_CNT_WIDTH-1:0]    trig_delay;
   logic [TRIG_CNT_WIDTH-1:0]    trig_width;
   logic [CAPTURE_LEN_WIDTH-1:0] capture_len;

   // events
   logic                         evt_valid;
   logic [1:0]                   evt_cmd;
   logic [7:0]                   evt_data;
   logic [3:0]                   evt_stat;
   logic [TS_FULL_WIDTH-1:0]     evt_time;
   logic                         pkt_start;
   logic                         match;

   // status and fifo
   logic                         capturing;
   logic                         capture_done;
   logic                         trig_done;
   logic                         fifo_pop;
   logic                         fifo_empty;
   logic                         fifo_full;
   fifo_word_u                   fifo_head;

   pw_reg_file i_reg_file (
      .fe_clk         (fe_clk),
      .rst_n_i        (rst_n_i),
      .reg_addr_i     (reg_addr_i),
      .reg_wdata_i    (reg_wdata_i),
      .reg_wr_i       (reg_wr_i),
      .reg_rd_i       (reg_rd_i),
      .capturing_i    (capturing),
      .capture_done_i (capture_done),
      .trig_done_i    (trig_done),
      .fifo_empty_i   (fifo_empty),
      .fifo_full_i    (fifo_full),
      .fifo_head_i    (fifo_head),
      .reg_rdata_o    (reg_rdata_o),
      .arm_o          (arm),
      .trig_enable_o  (trig_enable),
      .pattern_o      (pattern),
      .mask_o         (mask),
      .trig_delay_o   (trig_delay),
      .trig_width_o   (trig_width),
      .capture_len_o  (capture_len),
      .fifo_pop_o     (fifo_pop)
   );

   ////////////////////////////////////////
   // receive, match, trigger
   ////////////////////////////////////////
   pw_fe_rx i_fe_rx (
      .fe_clk        (fe_clk),
      .rst_n_i       (rst_n_i),
      .fe_data_i     (fe_data_i),
      .fe_rxvalid_i  (fe_rxvalid_i),
      .fe_rxactive_i (fe_rxactive_i),
      .fe_rxerror_i  (fe_rxerror_i),
      .fe_sessvld_i  (fe_sessvld_i),
      .fe_vbusvld_i  (fe_vbusvld_i),
      .evt_valid_o   (evt_valid),
      .evt_cmd_o     (evt_cmd),
      .evt_data_o    (evt_data),
      .evt_stat_o    (evt_stat),
      .evt_time_o    (evt_time),
      .pkt_start_o   (pkt_start)
   );

   pw_pattern_match i_pattern_match (
      .fe_clk      (fe_clk),
      .rst_n_i     (rst_n_i),
      .arm_i       (arm),
      .pkt_start_i (pkt_start),
      .evt_valid_i (evt_valid),
      .evt_cmd_i   (evt_cmd),
      .evt_data_i  (evt_data),
      .pattern_i   (pattern),
      .mask_i      (mask),
      .match_o     (match)
   );

   pw_trigger i_trigger (
      .fe_clk        (fe_clk),
      .rst_n_i       (rst_n_i),
      .match_i       (match),
      .trig_enable_i (trig_enable),
      .trig_delay_i  (trig_delay),
      .trig_width_i  (trig_width),
      .cw_trig_o     (cw_trig_o),
      .trig_done_o   (trig_done)
   );

   pw_capture_fifo i_capture_fifo (
      .fe_clk         (fe_clk),
      .rst_n_i        (rst_n_i),
      .evt_valid_i    (evt_valid),
      .evt_cmd_i      (evt_cmd),
      .evt_data_i     (evt_data),
      .evt_stat_i     (evt_stat),
      .evt_time_i     (evt_time),
      .match_i        (match),
      .capture_len_i  (capture_len),
      .fifo_pop_i     (fifo_pop),
      .capturing_o    (capturing),
      .capture_done_o (capture_done),
      .fifo_head_o    (fifo_head),
      .fifo_empty_o   (fifo_empty),
      .fifo_full_o    (fifo_full)
   );

endmodule

// ==== pw_properties.sv ====
module pw_properties (
   input logic                             fe_clk,
   input logic                             rst_n_i,
   input logic [pw_pkg::FIFO_ADDR_WIDTH:0] wr_ptr_i,
   input logic                             fifo_full_i,
   input logic                             capturing_i,
   input logic                             match_i,
   input logic                             cw_trig_i,
   input logic                             trig_enable_i
);
   timeunit 1ns;
   timeprecision 100ps;

   // write pointer frozen while full
   no_write_when_full: assert property (@(posedge fe_clk) disable iff (!rst_n_i)
      fifo_full_i |=> $stable(wr_ptr_i))
      else $error("fifo written while full");

   // enable also held at the edge that raised or kept the pulse
   trig_needs_enable: assert property (@(posedge fe_clk) disable iff (!rst_n_i)
      cw_trig_i |-> trig_enable_i && $past(trig_enable_i))
      else $error("cw_trig high with trigger disabled");

   // capture only starts one cycle after a match
   capture_after_match: assert property (@(posedge fe_clk) disable iff (!rst_n_i)
      $rose(capturing_i) |-> $past(match_i))
      else $error("capturing rose without a match");

endmodule

////////////////////////////////////////
// attach to capture and trigger stages
////////////////////////////////////////
bind pw_capture_fifo pw_properties i_capture_props (
   .fe_clk        (fe_clk),
   .rst_n_i       (rst_n_i),
   .wr_ptr_i      (wr_ptr),
   .fifo_full_i   (fifo_full_o),
   .capturing_i   (capturing_o),
   .match_i       (match_i),
   .cw_trig_i     (1'b0),
   .trig_enable_i (1'b1)
);

bind pw_trigger pw_properties i_trigger_props (
   .fe_clk        (fe_clk),
   .rst_n_i       (rst_n_i),
   .wr_ptr_i      ('0),
   .fifo_full_i   (1'b0),
   .capturing_i   (1'b0),
   .match_i       (match_i),
   .cw_trig_i     (cw_trig_o),
   .trig_enable_i (trig_enable_i)
);

// ==== tb_phywhisperer.sv ====
module tb_phywhisperer;
   timeunit 1ns;
   timeprecision 100ps;
   import pw_pkg::*;

   localparam int TRIG_TIMEOUT = 300;  // cycles allowed for one trigger pulse
   localparam int QUIET_CYCLES = 24;
   localparam int PKT_MAX      = 32;

   logic       fe_clk;
   logic       rst_n;
   logic [7:0] fe_data;
   logic       fe_rxvalid;
   logic       fe_rxactive;
   logic       fe_rxerror;
   logic       fe_sessvld;
   logic       fe_vbusvld;
   logic [7:0] reg_addr;
   logic [7:0] reg_wdata;
   logic       reg_wr;
   logic       reg_rd;
   logic [7:0] reg_rdata;
   logic       cw_trig;

   int         cyc;              // rising edges since time zero
   int         value_errors;
   int         other_errors;
   logic       aborted;
   int         byte4_cyc;        // edge that sampled the fourth byte
   int         pulses_expected;
   int         pulse_cnt;
   int         pulse_ends;
   int         rise_cyc;
   int         width_cnt;
   logic       trig_prev;
   logic [7:0] shadow_delay;     // copies of the delay and width registers
   logic [7:0] shadow_width;
   logic [7:0] last_ts;
   logic       ts_valid;
   logic [7:0] pkt_buf [PKT_MAX];
   int         pkt_len;

   phywhisperer_top i_phywhisperer_top (
      .fe_clk        (fe_clk),
      .rst_n_i       (rst_n),
      .fe_data_i     (fe_data),
      .fe_rxvalid_i  (fe_rxvalid),
      .fe_rxactive_i (fe_rxactive),
      .fe_rxerror_i  (fe_rxerror),
      .fe_sessvld_i  (fe_sessvld),
      .fe_vbusvld_i  (fe_vbusvld),
      .reg_addr_i    (reg_addr),
      .reg_wdata_i   (reg_wdata),
      .reg_wr_i      (reg_wr),
      .reg_rd_i      (reg_rd),
      .reg_rdata_o   (reg_rdata),
      .cw_trig_o     (cw_trig)
   );

   always #20 fe_clk = ~fe_clk;

   always @(posedge fe_clk) cyc <= cyc + 1;

   ////////////////////////////////////////
   // trigger pulse monitor
   ////////////////////////////////////////
   always @(negedge fe_clk) begin
      trig_prev <= cw_trig;
      if (cw_trig && !trig_prev) begin
         pulse_cnt <= pulse_cnt + 1;
         rise_cyc  <= cyc;
         width_cnt <= 1;
      end else if (cw_trig) begin
         width_cnt <= width_cnt + 1;
      end else if (trig_prev) begin
         pulse_ends <= pulse_ends + 1;  // pulse just fell
      end
   end

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected) begin
         $display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
         value_errors++;
      end
   endtask

   task automatic reg_write(input logic [7:0] addr, input logic [7:0] data);
      reg_addr  = addr;
      reg_wdata = data;
      reg_wr    = 1'b1;
      @(negedge fe_clk);
      reg_wr = 1'b0;
   endtask

   task automatic reg_read(input logic [7:0] addr, output logic [7:0] data);
      reg_addr = addr;
      reg_rd   = 1'b1;
      @(negedge fe_clk);
      reg_rd = 1'b0;
      data   = reg_rdata;  // valid one cycle after the strobe
   endtask

   // pop the head and read it back, low byte first
   task automatic pop_entry(output logic [17:0] word);
      logic [7:0] b0;
      logic [7:0] b1;
      logic [7:0] b2;
      logic [7:0] ts;
      logic [7:0] step;
      reg_write(REG_FIFO_POP, 8'h00);
      reg_read(REG_FIFO_DATA0, b0);
      reg_read(REG_FIFO_DATA0 + 8'd1, b1);
      reg_read(REG_FIFO_DATA0 + 8'd2, b2);
      word = {b2[1:0], b1, b0};
      ts   = (word[17:16] == CMD_STAT) ? word[7:0] : word[15:8];
      if (ts_valid) begin
         step = ts - last_ts;  // forward modulo 256
         check("fifo_ts_forward", step < 8'd128, 1);
      end
      last_ts  = ts;
      ts_valid = 1'b1;
   endtask

   task automatic send_packet();
      int gap;
      fe_rxactive = 1'b1;
      repeat (2) @(negedge fe_clk);
      for (int i = 0; i < pkt_len; i++) begin
         if (i == PATTERN_BYTES - 1)
            byte4_cyc = cyc + 1;
         fe_data    = pkt_buf[i];
         fe_rxvalid = 1'b1;
         @(negedge fe_clk);
         fe_rxvalid = 1'b0;
         @(negedge fe_clk);  // one byte per two cycles
      end
      fe_rxactive = 1'b0;
      gap = 4 + ($urandom % 8);
      repeat (gap) @(negedge fe_clk);
   endtask

   task automatic expect_trigger();
      int waited;
      pulses_expected++;
      waited = 0;
      while (pulse_ends < pulses_expected && waited < TRIG_TIMEOUT) begin
         @(negedge fe_clk);
         waited++;
      end
      if (pulse_ends < pulses_expected) begin
         $display("trigger pulse %0d did not finish within %0d cycles",
                  pulses_expected, TRIG_TIMEOUT);
         other_errors++;
         aborted = 1'b1;
      end else begin
         check("cw_trig_o rise", rise_cyc - byte4_cyc, shadow_delay + 4);
         check("cw_trig_o width", width_cnt, shadow_width);
         check("cw_trig_o pulses", pulse_cnt, pulses_expected);
      end
   endtask

   task automatic expect_no_trigger();
      for (int i = 0; i < QUIET_CYCLES; i++)
         @(negedge fe_clk);
      check("cw_trig_o pulses", pulse_cnt, pulses_expected);
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////
   initial begin
      int               fd;
      int               code;
      int               n;
      logic [7:0]       op;
      logic [7:0]       arg_a;
      logic [7:0]       arg_b;
      logic [7:0]       rd;
      logic [17:0]      word;
      logic [8*128-1:0] line_buf;

      void'($urandom(19));
      fe_clk      = 1'b0;
      rst_n       = 1'b0;
      fe_data     = 8'h00;
      fe_rxvalid  = 1'b0;
      fe_rxactive = 1'b0;
      fe_rxerror  = 1'b0;
      fe_sessvld  = 1'b1;  // session and vbus valid for the whole run
      fe_vbusvld  = 1'b1;
      reg_addr    = 8'h00;
      reg_wdata   = 8'h00;
      reg_wr      = 1'b0;
      reg_rd      = 1'b0;
      trig_prev   = 1'b0;
      aborted     = 1'b0;
      ts_valid    = 1'b0;
      last_ts     = 8'h00;
      shadow_delay = 8'h00;
      shadow_width = 8'h00;
      repeat (5) @(negedge fe_clk);
      rst_n = 1'b1;
      @(negedge fe_clk);

      fd = $fopen("tb_input.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file tb_input.txt");
         other_errors++;
         aborted = 1'b1;
      end
      while (!aborted) begin
         code = $fscanf(fd, " %c", op);
         if (code != 1)
            break;
         case (op)
            "#": code = $fgets(line_buf, fd);
            "W": begin
               code = $fscanf(fd, "%h %h", arg_a, arg_b);
               reg_write(arg_a, arg_b);
               if (arg_a == REG_TRIG_DELAY)
                  shadow_delay = arg_b;
               if (arg_a == REG_TRIG_WIDTH)
                  shadow_width = arg_b;
               if (arg_a == REG_CTRL)
                  ts_valid = 1'b0;  // new capture, new time base
            end
            "C": begin
               code = $fscanf(fd, "%h %h", arg_a, arg_b);
               reg_read(arg_a, rd);
               check($sformatf("reg_rdata_o[%02h]", arg_a), rd, arg_b);
            end
            "P": begin
               code = $fscanf(fd, "%h", n);
               pkt_len = (n > PKT_MAX) ? PKT_MAX : n;
               for (int i = 0; i < pkt_len; i++) begin
                  code = $fscanf(fd, "%h", arg_a);
                  pkt_buf[i] = arg_a;
               end
               send_packet();
            end
            "T": expect_trigger();
            "N": expect_no_trigger();
            "D": begin
               code = $fscanf(fd, "%h", arg_a);
               pop_entry(word);
               check("fifo cmd", word[17:16], CMD_DATA);
               check("fifo data", word[7:0], arg_a);
            end
            "X": begin
               code = $fscanf(fd, "%h", arg_a);
               pop_entry(word);
               check("fifo cmd", word[17:16], CMD_STAT);
               check("fifo stat", word[15:12], arg_a[3:0]);
            end
            "K": begin
               code = $fscanf(fd, "%h", n);
               for (int i = 0; i < n; i++) begin
                  reg_read(REG_STATUS, rd);
                  check("fifo_empty", rd[1], 0);
                  pop_entry(word);
               end
            end
            default: begin
               $display("unknown command '%c' in tb_input.txt", op);
               other_errors++;
               aborted = 1'b1;
            end
         endcase
      end
      if (fd != 0)
         $fclose(fd);

      $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// ==== tb_input.txt ====
# op and hex args: W addr data, C addr expected, P count bytes, T trigger, N no trigger
# D expected data byte, X expected status (rxactive rxerror sessvld vbusvld), K pops
C 00 00
C 01 02
N
W 04 a5
W 05 3c
W 06 0f
W 07 96
W 08 ff
W 09 ff
W 0a f0
W 0b ff
W 0c 03
W 0d 02
W 0e 05
W 00 03
P 4 a5 3c 1f 96
N
C 01 02
P 6 a5 3c 0a 96 c3 e1
T
C 01 09
P 4 a5 3c 0f 96
N
C 00 02
C 01 08
D c3
D e1
X 03
X 0b
D a5
C 01 0a
W 0c 00
W 0d 01
W 0e 14
W 00 03
P 6 a5 3c 05 96 11 22
T
P 6 01 02 03 04 05 06
P 6 07 08 09 0a 0b 0c
C 01 0d
K 10
C 01 0b

// ==== compile.f ====
pw_pkg.sv
pw_reg_file.sv
pw_fe_rx.sv
pw_pattern_match.sv
pw_trigger.sv
pw_capture_fifo.sv
phywhisperer_top.sv
pw_properties.sv
tb_phywhisperer.sv
